// ==== verilog/macc_pkg.sv ====
package macc_pkg;

   // ****************************************
   // data widths.
   // ****************************************

   // one operand, two of them share a host word.
   typedef logic signed [15:0] operand_t;

   // accumulator and result word.
   typedef logic signed [31:0] acc_t;

   typedef logic [7:0]  loop_t;
   typedef logic [3:0]  delay_t;
   typedef logic [3:0]  tab_addr_t;

   // host bus.
   typedef logic [5:0]  bus_addr_t;
   typedef logic [31:0] bus_data_t;

   // op_msub loads the first product of a period and subtracts the rest.
   typedef enum logic {
      op_macc = 1'b0,
      op_msub = 1'b1
   } macc_op_e;

   // ****************************************
   // host register map.
   // ****************************************

   localparam bus_addr_t addr_opcode      = 6'd0;
   localparam bus_addr_t addr_iter        = 6'd1;
   localparam bus_addr_t addr_period      = 6'd2;
   localparam bus_addr_t addr_delay       = 6'd3;
   localparam bus_addr_t addr_start       = 6'd4;
   localparam bus_addr_t addr_status      = 6'd5;
   // 16 words each.
   localparam bus_addr_t addr_table_base  = 6'd16;
   localparam bus_addr_t addr_result_base = 6'd32;

endpackage

// ==== verilog/operand_table.sv ====
`timescale 1ns/100ps

module operand_table import macc_pkg::*; #(
   parameter int TABLE_DEPTH = 16
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      tab_we,
   input  tab_addr_t tab_addr,
   input  bus_data_t tab_wdata,
   input  logic      run,
   input  logic      running,
   output operand_t  in0,
   output operand_t  in1
);

   // in0 in the low half, in1 in the high half.
   bus_data_t mem [TABLE_DEPTH];
   tab_addr_t rd_ptr;
   bus_data_t pair;

   // ****************************************
   // host write port.
   // ****************************************

   always_ff @(posedge clk) begin
      if (tab_we) mem[tab_addr] <= tab_wdata;
   end

   // ****************************************
   // stream read pointer.
   // ****************************************

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (run) begin
         rd_ptr <= '0;
      end else if (running) begin
         // wraps at the table depth.
         if (rd_ptr == tab_addr_t'(TABLE_DEPTH - 1)) rd_ptr <= '0;
         else rd_ptr <= rd_ptr + 4'd1;
      end
   end

   assign pair = mem[rd_ptr];
   assign in0  = operand_t'(pair[15:0]);
   assign in1  = operand_t'(pair[31:16]);

endmodule

// ==== verilog/result_buffer.sv ====
`timescale 1ns/100ps

module result_buffer import macc_pkg::*; #(
   parameter int TABLE_DEPTH = 16
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  logic      out_valid,
   input  acc_t      out0,
   input  tab_addr_t res_raddr,
   output acc_t      res_rdata,
   output loop_t     res_count
);

   acc_t mem [TABLE_DEPTH];
   logic full;

   assign full = (res_count >= TABLE_DEPTH);

   // ****************************************
   // result store.
   // ****************************************

   // a full buffer keeps the sums already stored.
   always_ff @(posedge clk) begin
      if (out_valid && !full) mem[tab_addr_t'(res_count)] <= out0;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         res_count <= '0;
      end else if (run) begin
         res_count <= '0;
      end else if (out_valid && !full) begin
         res_count <= res_count + 8'd1;
      end
   end

   // host read, no wait state.
   assign res_rdata = mem[res_raddr];

   // iter must not exceed the buffer depth.
   no_write_when_full: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> !full);

endmodule

// ==== verilog/macc_unit.sv ====
`timescale 1ns/100ps

module macc_unit import macc_pkg::*; #(
   parameter int ACC_W = 32
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   input  logic     running,
   input  macc_op_e opcode,
   input  loop_t    iter,
   input  loop_t    period,
   input  delay_t   delay0,
   input  operand_t in0,
   input  operand_t in1,
   output acc_t     out0,
   output logic     out_valid,
   output logic     done
);

   // operand and product registers sit ahead of the accumulator.
   localparam int FILL = 2;

   logic [4:0] delay_cnt;
   loop_t      period_cnt;
   loop_t      iter_cnt;
   logic       active;
   logic       last_tap;

   operand_t               in0_reg;
   operand_t               in1_reg;
   logic signed [ACC_W-1:0] prod;
   logic signed [ACC_W-1:0] acc;

   // a period of zero behaves like a period of one.
   assign last_tap = (period == '0) || (period_cnt == period - 8'd1);

   assign active = running && (delay_cnt == '0) && (iter_cnt != iter);

   // ****************************************
   // delay, period and iteration counters.
   // ****************************************

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay_cnt  <= '0;
         period_cnt <= '0;
         iter_cnt   <= '0;
         out_valid  <= 1'b0;
         done       <= 1'b0;
      end else if (run) begin
         delay_cnt  <= {1'b0, delay0} + 5'(FILL);
         period_cnt <= '0;
         iter_cnt   <= '0;
         out_valid  <= 1'b0;
         done       <= 1'b0;
      end else begin
         // the accumulator holds the finished sum one cycle after its last tap.
         out_valid <= active && last_tap;
         if (running) begin
            if (delay_cnt != '0) delay_cnt <= delay_cnt - 5'd1;
            if (active) begin
               if (last_tap) begin
                  period_cnt <= '0;
                  iter_cnt   <= iter_cnt + 8'd1;
               end else begin
                  period_cnt <= period_cnt + 8'd1;
               end
            end
            // with iter zero this fires while the delay still runs.
            if (iter_cnt == iter && !done) done <= 1'b1;
         end
      end
   end

   // ****************************************
   // datapath.
   // ****************************************

   always_ff @(posedge clk) begin
      if (running) begin
         in0_reg <= in0;
         in1_reg <= in1;
         prod    <= in0_reg * in1_reg;
         // reload on the first tap of every period.
         if (period_cnt == '0) begin
            acc <= prod;
         end else if (opcode == op_macc) begin
            acc <= acc + prod;
         end else begin
            acc <= acc - prod;
         end
      end
   end

   assign out0 = acc_t'(acc);

   valid_while_running: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> running);

   done_held_until_run: assert property (@(posedge clk) disable iff (rst)
      $fell(done) |-> $past(run));

endmodule

// ==== verilog/macc_regs.sv ====
`timescale 1ns/100ps

module macc_regs import macc_pkg::*; #(
   parameter int TABLE_DEPTH = 16
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      host_req,
   input  logic      host_we,
   input  bus_addr_t host_addr,
   input  bus_data_t host_wdata,
   output logic      host_ack,
   output bus_data_t host_rdata,
   output logic      tab_we,
   output tab_addr_t tab_addr,
   output bus_data_t tab_wdata,
   output tab_addr_t res_raddr,
   input  acc_t      res_rdata,
   input  loop_t     res_count,
   output macc_op_e  opcode,
   output loop_t     iter,
   output loop_t     period,
   output delay_t    delay0,
   output logic      run,
   output logic      busy,
   input  logic      done
);

   typedef enum logic [1:0] {
      st_idle,
      st_ack,
      st_wait
   } hs_state_e;

   hs_state_e state;
   logic      access;
   logic      tab_hit;
   logic      res_hit;
   bus_data_t read_word;

   // a request is taken only in idle, once per handshake.
   assign access = (state == st_idle) && host_req;

   assign tab_hit = (host_addr >= addr_table_base) &&
                    (host_addr < addr_table_base + TABLE_DEPTH);
   assign res_hit = (host_addr >= addr_result_base) &&
                    (host_addr < addr_result_base + TABLE_DEPTH);

   assign res_raddr = host_addr[3:0];

   // ack is high for the whole time the FSM is away from idle.
   assign host_ack = (state != st_idle);

   // ****************************************
   // four-phase handshake.
   // ****************************************

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (host_req) state <= st_ack;
            st_ack:  state <= st_wait;
            st_wait: if (!host_req) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   // read mux.
   always_comb begin
      read_word = '0;
      if (res_hit) begin
         read_word = res_rdata;
      end else begin
         case (host_addr)
            addr_opcode: read_word = {31'h0, opcode};
            addr_iter:   read_word = {24'h0, iter};
            addr_period: read_word = {24'h0, period};
            addr_delay:  read_word = {28'h0, delay0};
            addr_status: read_word = {16'h0, res_count, 6'h0, done, busy};
            default:     read_word = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (access && !host_we) host_rdata <= read_word;
      if (access) begin
         tab_addr  <= host_addr[3:0];
         tab_wdata <= host_wdata;
      end
   end

   // ****************************************
   // configuration and run control.
   // ****************************************

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         opcode <= op_macc;
         iter   <= '0;
         period <= '0;
         delay0 <= '0;
         tab_we <= 1'b0;
         run    <= 1'b0;
         busy   <= 1'b0;
      end else begin
         tab_we <= access && host_we && tab_hit && !busy;
         run    <= access && host_we && (host_addr == addr_start) && !busy;
         if (access && host_we) begin
            case (host_addr)
               addr_opcode: opcode <= macc_op_e'(host_wdata[0]);
               addr_iter:   iter   <= host_wdata[7:0];
               addr_period: period <= host_wdata[7:0];
               addr_delay:  delay0 <= host_wdata[3:0];
               default: ;
            endcase
         end
         // run wins over a done left over from the previous job.
         if (run) busy <= 1'b1;
         else if (done) busy <= 1'b0;
      end
   end

   ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      $rose(host_ack) |-> $past(host_req));

endmodule

// ==== verilog/macc_top.sv ====
`timescale 1ns/100ps

module macc_top import macc_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      host_req,
   input  logic      host_we,
   input  bus_addr_t host_addr,
   input  bus_data_t host_wdata,
   output logic      host_ack,
   output bus_data_t host_rdata,
   output logic      busy
);

   localparam int TABLE_DEPTH = 16;
   localparam int ACC_W       = 32;

   logic      tab_we;
   tab_addr_t tab_addr;
   bus_data_t tab_wdata;
   tab_addr_t res_raddr;
   acc_t      res_rdata;
   loop_t     res_count;
   macc_op_e  opcode;
   loop_t     iter;
   loop_t     period;
   delay_t    delay0;
   logic      run;
   logic      done;
   operand_t  in0;
   operand_t  in1;
   acc_t      out0;
   logic      out_valid;

   // ****************************************
   // host side.
   // ****************************************

   macc_regs #(.TABLE_DEPTH(TABLE_DEPTH)) u_regs (
      .clk(clk), .rst(rst),
      .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
      .tab_we(tab_we), .tab_addr(tab_addr), .tab_wdata(tab_wdata),
      .res_raddr(res_raddr), .res_rdata(res_rdata), .res_count(res_count),
      .opcode(opcode), .iter(iter), .period(period), .delay0(delay0),
      .run(run), .busy(busy), .done(done)
   );

   // ****************************************
   // engine, busy doubles as running.
   // ****************************************

   operand_table #(.TABLE_DEPTH(TABLE_DEPTH)) u_table (
      .clk(clk), .rst(rst),
      .tab_we(tab_we), .tab_addr(tab_addr), .tab_wdata(tab_wdata),
      .run(run), .running(busy), .in0(in0), .in1(in1)
   );

   macc_unit #(.ACC_W(ACC_W)) u_unit (
      .clk(clk), .rst(rst), .run(run), .running(busy),
      .opcode(opcode), .iter(iter), .period(period), .delay0(delay0),
      .in0(in0), .in1(in1), .out0(out0), .out_valid(out_valid), .done(done)
   );

   result_buffer #(.TABLE_DEPTH(TABLE_DEPTH)) u_results (
      .clk(clk), .rst(rst), .run(run),
      .out_valid(out_valid), .out0(out0),
      .res_raddr(res_raddr), .res_rdata(res_rdata), .res_count(res_count)
   );

endmodule

// ==== sim/tb_macc_tasks.svh ====
`ifndef TB_MACC_TASKS_SVH
`define TB_MACC_TASKS_SVH

// ****************************************
// four-phase host bus handshake.
// ****************************************

// every call starts and ends just after a rising edge.
task automatic wait_ack(input logic level);
   do begin
      @(posedge clk);
      #1;
   end while (host_ack !== level);
endtask

task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
   host_req   = 1'b1;
   host_we    = 1'b1;
   host_addr  = addr;
   host_wdata = data;
   wait_ack(1'b1);
   host_req = 1'b0;
   host_we  = 1'b0;
   wait_ack(1'b0);
endtask

task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
   host_req  = 1'b1;
   host_we   = 1'b0;
   host_addr = addr;
   wait_ack(1'b1);
   data     = host_rdata;
   host_req = 1'b0;
   wait_ack(1'b0);
endtask

// ****************************************
// stimulus and reference model.
// ****************************************

// upper half of the state since the low bits of an lcg repeat quickly.
function automatic logic [15:0] lcg_half();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return lcg_state[31:16];
endfunction

task automatic fill_known();
   for (int i = 0; i < 16; i++) begin
      table_words[i][15:0]  = 16'(i * 37 - 250);
      table_words[i][31:16] = 16'(300 - i * i * 5);
   end
endtask

// sum of period j with the stream index wrapping at the table depth.
function automatic acc_t expected_sum(input macc_op_e op, input int d, input int p,
                                      input int j);
   acc_t     sum;
   acc_t     prod;
   operand_t a;
   operand_t b;
   int       len;
   int       idx;
   len = (p == 0) ? 1 : p;
   sum = '0;
   for (int t = 0; t < len; t++) begin
      idx  = (d + j * len + t) % 16;
      a    = table_words[idx][15:0];
      b    = table_words[idx][31:16];
      prod = a * b;
      if (op == op_msub && t > 0) sum = sum - prod;
      else sum = sum + prod;
   end
   return sum;
endfunction

// ****************************************
// job control and checks.
// ****************************************

task automatic start_job(input macc_op_e op, input int d, input int p, input int n);
   for (int i = 0; i < 16; i++) begin
      bus_write(addr_table_base + bus_addr_t'(i), table_words[i]);
   end
   bus_write(addr_opcode, bus_data_t'(op));
   bus_write(addr_iter, bus_data_t'(n));
   bus_write(addr_period, bus_data_t'(p));
   bus_write(addr_delay, bus_data_t'(d));
   bus_write(addr_start, 32'd1);
endtask

task automatic check_job(input macc_op_e op, input int d, input int p, input int n);
   bus_data_t status;
   bus_data_t word;
   acc_t      want;
   do begin
      bus_read(addr_status, status);
   end while (status[0]);
   if (status[1] !== 1'b1) begin
      $display("Fail at %0t: done bit is low after busy fell", $time);
      errors++;
   end
   if (status[15:8] !== 8'(n)) begin
      $display("Fail at %0t: result count %0d, expected %0d", $time, status[15:8], n);
      errors++;
   end
   for (int j = 0; j < n; j++) begin
      bus_read(addr_result_base + bus_addr_t'(j), word);
      want = expected_sum(op, d, p, j);
      if (word !== want) begin
         $display("Fail at %0t: result %0d is %0d, expected %0d", $time, j, $signed(word), want);
         errors++;
      end
   end
endtask

task automatic run_job(input macc_op_e op, input int d, input int p, input int n);
   start_job(op, d, p, n);
   check_job(op, d, p, n);
endtask

task automatic check_register(input bus_addr_t addr, input bus_data_t wdata,
                              input bus_data_t want);
   bus_data_t word;
   bus_write(addr, wdata);
   bus_read(addr, word);
   if (word !== want) begin
      $display("Fail at %0t: register %0d reads %h, expected %h", $time, addr, word, want);
      errors++;
   end
endtask

task automatic report_test(input string name);
   tests_run++;
   if (errors == last_errors) begin
      $display("test %-22s ok", name);
   end else begin
      $display("test %-22s %0d errors", name, errors - last_errors);
      tests_failed++;
   end
   last_errors = errors;
endtask

// ****************************************
// directed tests.
// ****************************************

task automatic test_registers();
   bus_data_t word;
   bus_read(addr_status, word);
   if (word !== '0 || busy !== 1'b0) begin
      $display("Fail at %0t: status %h busy %b after reset", $time, word, busy);
      errors++;
   end
   check_register(addr_iter, 32'h5a, 32'h5a);
   check_register(addr_period, 32'h1c3, 32'hc3);
   check_register(addr_delay, 32'hff, 32'hf);
   check_register(addr_opcode, 32'h3, 32'h1);
endtask

task automatic test_single_period();
   fill_known();
   run_job(op_macc, 0, 4, 1);
endtask

task automatic test_delayed_periods();
   fill_known();
   run_job(op_macc, 3, 3, 4);
endtask

task automatic test_subtract();
   fill_known();
   run_job(op_msub, 1, 5, 2);
endtask

task automatic test_zero_and_restart();
   bus_data_t status;
   logic [7:0] count0;
   fill_known();
   run_job(op_macc, 2, 4, 0);
   start_job(op_macc, 15, 12, 8);
   do begin
      bus_read(addr_status, status);
   end while (status[0] && status[15:8] == 8'd0);
   if (status[0] !== 1'b1) begin
      $display("the long job ended before a second start could be written");
      errors++;
   end
   count0 = status[15:8];
   bus_write(addr_start, 32'd1);
   bus_read(addr_status, status);
   if (status[15:8] < count0) begin
      $display("Fail at %0t: count fell from %0d to %0d", $time, count0, status[15:8]);
      errors++;
   end
   check_job(op_macc, 15, 12, 8);
endtask

// p and n keep the stream longer than the table, so the index wraps.
task automatic test_random();
   int p;
   int n;
   int d;
   for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 16; i++) begin
         table_words[i] = {lcg_half(), lcg_half()};
      end
      p = lcg_half() % 5 + 4;
      n = lcg_half() % 4 + 5;
      d = lcg_half() % 16;
      run_job((k == 0) ? op_macc : op_msub, d, p, n);
   end
endtask

`endif

// ==== sim/tb_macc.sv ====
`timescale 1ns/100ps

module tb_macc import macc_pkg::*; ();

   // about six jobs of up to 600 cycles each, with a wide margin.
   localparam int CYCLE_LIMIT = 20000;

   logic      clk;
   logic      rst;
   logic      host_req;
   logic      host_we;
   bus_addr_t host_addr;
   bus_data_t host_wdata;
   logic      host_ack;
   bus_data_t host_rdata;
   logic      busy;

   int          errors       = 0;
   int          last_errors  = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   int          cycles       = 0;
   int unsigned lcg_state    = 94048;

   // what the host wrote into the operand table, used by the model.
   bus_data_t table_words [16];

   macc_top u_dut (
      .clk(clk), .rst(rst),
      .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
      .busy(busy)
   );

   `include "tb_macc_tasks.svh"

   // ****************************************
   // clock and timeout.
   // ****************************************

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the test sequence did not end within %0d cycles", CYCLE_LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ****************************************
   // test sequence.
   // ****************************************

   initial begin
      rst        = 1'b1;
      host_req   = 1'b0;
      host_we    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      test_registers();
      report_test("register access");
      test_single_period();
      report_test("single period");
      test_delayed_periods();
      report_test("periods with delay");
      test_subtract();
      report_test("subtract mode");
      test_zero_and_restart();
      report_test("zero iter, start busy");
      test_random();
      report_test("random jobs");

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+sim
verilog/macc_pkg.sv
verilog/operand_table.sv
verilog/result_buffer.sv
verilog/macc_unit.sv
verilog/macc_regs.sv
verilog/macc_top.sv
sim/tb_macc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the macc testbench with verilator, then check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_macc \
   > build.log 2>&1 \
   && ./obj_dir/Vtb_macc > sim.log 2>&1 \
   || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log \
   && echo "simulation ok" \
   || { echo "simulation reported failure, see sim.log"; exit 1; }
